/* vlog.f */
logic/rv_pkg.sv
logic/rv_fetch.sv
logic/rv_regfile.sv
logic/rv_decode.sv
logic/rv_alu.sv
logic/rv_mem_stage.sv
logic/rv_writeback.sv
logic/rv_core.sv
testbench/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard logic/*.sv) $(wildcard testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ns

module tb_rv_core;

    localparam int RAM_WORDS   = 64;      // Bus RAM, indexed by mem_addr[7:2]
    localparam int GROUPS      = 155;     // Op plus store pairs after the preamble
    localparam int RUN_TIMEOUT = 20000;   // Cycles allowed for the whole program

    logic              CK_REF;
    logic              RST_N;
    logic              halt;
    rv_pkg::word_t     inst_data;
    rv_pkg::word_t     mem_rd_data;
    rv_pkg::word_t     inst_addr;
    logic              mem_read_wrn;
    rv_pkg::mem_addr_t mem_addr;
    rv_pkg::word_t     mem_wr_data;

    rv_pkg::word_t     prog [$];              // Code image, one word per address step
    rv_pkg::word_t     ram [RAM_WORDS];       // Data memory behind the DUT bus
    rv_pkg::word_t     model_ram [RAM_WORDS];
    rv_pkg::word_t     model_regs [rv_pkg::REG_COUNT];
    rv_pkg::mem_addr_t exp_addr_q [$];        // Expected stores, in program order
    rv_pkg::word_t     exp_data_q [$];
    logic [31:0]       lcg_state;
    rv_pkg::word_t     fetch_addr;            // PC model, counts non-halted edges
    int                halt_left;
    int                cycles;

    rv_core rv_core_i (
        .CK_REF(CK_REF), .RST_N(RST_N), .halt(halt),
        .inst_data(inst_data), .mem_rd_data(mem_rd_data), .inst_addr(inst_addr),
        .mem_read_wrn(mem_read_wrn), .mem_addr(mem_addr), .mem_wr_data(mem_wr_data)
    );

    initial begin
        CK_REF = 1'b0;
        forever #4 CK_REF = ~CK_REF;   // 8 ns period
    end

    // ******************************
    // Helpers and reference model
    // ******************************
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15);   // Fold high bits into the weak low ones
    endfunction

    function automatic int pick(int n);   // 0 .. n-1
        return int'(next_rand() % 32'(n));
    endfunction

    // RV32I integer op by funct3, alt selects SUB or SRA
    function automatic rv_pkg::word_t alu_model(logic [2:0] f3, logic alt,
                                                rv_pkg::word_t a, rv_pkg::word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Load extension by funct3; SB, SH and SW use the same sign-extending codes
    function automatic rv_pkg::word_t sized_value(logic [2:0] f3, rv_pkg::word_t w);
        case (f3)
            3'b000:  return {{24{w[7]}}, w[7:0]};
            3'b001:  return {{16{w[15]}}, w[15:0]};
            3'b100:  return {24'd0, w[7:0]};
            3'b101:  return {16'd0, w[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic rv_pkg::word_t code_word(rv_pkg::word_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < prog.size()) begin
            return prog[idx];
        end
        return rv_pkg::BUBBLE_WORD;   // Past the end of the program
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic append_instr(rv_pkg::word_t w);
        prog.push_back(w);
        repeat (4) prog.push_back(rv_pkg::BUBBLE_WORD);   // Covers the write-back latency
    endtask

    // ******************************
    // Program generator
    // ******************************
    task automatic build_program();
        rv_pkg::reg_idx_t rd, rs1, rs2, src;
        logic [2:0]       f3;
        logic [11:0]      imm;
        logic             alt;
        int               kind, k;
        rv_pkg::word_t    addr;
        // Seed x1..x31 with signed 12-bit values so later ops mix signs
        for (int r = 1; r < rv_pkg::REG_COUNT; r++) begin
            imm = 12'(next_rand());
            append_instr({imm, 5'd0, 3'b000, 5'(r), rv_pkg::OPC_OP_IMM});
            model_regs[r] = {{20{imm[11]}}, imm};
        end
        for (int g = 0; g < GROUPS; g++) begin
            kind = pick(4);
            rd   = 5'(1 + pick(31));   // Never x0
            rs1  = 5'(pick(32));
            src  = rd;                 // Store the fresh result
            f3   = 3'(pick(8));
            alt  = (f3 == 3'b101 || (kind == 1 && f3 == 3'b000)) ? 1'(pick(2)) : 1'b0;
            case (kind)
                0: begin
                    imm = 12'(next_rand());
                    if (f3 == 3'b001 || f3 == 3'b101) begin
                        imm = {1'b0, alt, 5'd0, imm[4:0]};   // Shamt form, bit 30 for SRAI
                    end
                    append_instr({imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM});
                    model_regs[rd] = alu_model(f3, alt, model_regs[rs1], {{20{imm[11]}}, imm});
                end
                1: begin
                    rs2 = 5'(pick(32));
                    append_instr({1'b0, alt, 5'd0, rs2, rs1, f3, rd, rv_pkg::OPC_OP});
                    model_regs[rd] = alu_model(f3, alt, model_regs[rs1], model_regs[rs2]);
                end
                2: begin
                    k    = pick(5);
                    f3   = (k < 3) ? 3'(k) : 3'(k + 1);   // LB LH LW LBU LHU
                    addr = rv_pkg::word_t'(4 * pick(RAM_WORDS));
                    append_instr({addr[11:0], 5'd0, f3, rd, rv_pkg::OPC_LOAD});
                    model_regs[rd] = sized_value(f3, model_ram[addr[7:2]]);
                end
                default: src = 5'(pick(32));   // Plain store of any register
            endcase
            f3   = 3'(pick(3));   // SB, SH or SW
            addr = rv_pkg::word_t'(4 * pick(RAM_WORDS));
            append_instr({addr[11:5], src, 5'd0, f3, addr[4:0], rv_pkg::OPC_STORE});
            model_ram[addr[7:2]] = sized_value(f3, model_regs[src]);   // Whole word replaced
            exp_addr_q.push_back(addr[15:0]);
            exp_data_q.push_back(model_ram[addr[7:2]]);
        end
    endtask

    task automatic check_store();
        rv_pkg::mem_addr_t ea;
        rv_pkg::word_t     ed;
        if (exp_addr_q.size() == 0) begin
            report_failure("A store reached the bus after the model ran out of stores");
        end else begin
            ea = exp_addr_q.pop_front();
            ed = exp_data_q.pop_front();
            assert (mem_addr == ea) else
                report_failure($sformatf("FAILED mem_addr: got %h expected %h", mem_addr, ea));
            assert (mem_wr_data == ed) else
                report_failure($sformatf("FAILED mem_wr_data: got %h expected %h",
                                         mem_wr_data, ed));
        end
    endtask

    // ******************************
    // Code memory, data RAM, halt
    // ******************************
    always @(posedge CK_REF) begin
        if (RST_N) begin
            assert (inst_addr == fetch_addr) else
                report_failure($sformatf("FAILED inst_addr: got %h expected %h",
                                         inst_addr, fetch_addr));
            if (!halt) begin
                fetch_addr = fetch_addr + 32'd4;   // DUT PC moved on this edge
            end
            inst_data <= code_word(fetch_addr);
            if (!mem_read_wrn) begin
                ram[mem_addr[7:2]] = mem_wr_data;   // Repeats while halted, same word
                if (!halt) begin
                    check_store();   // Counted once, at the edge that retires it
                end
            end else if (!halt) begin
                mem_rd_data <= ram[mem_addr[7:2]];   // Held through a halt for write-back
            end
            if (halt_left == 0 && pick(10) == 0) begin
                halt_left = 1 + pick(5);
            end
            if (halt_left > 0) begin
                halt <= 1'b1;
                halt_left--;
            end else begin
                halt <= 1'b0;
            end
        end
    end

    initial begin
        lcg_state   = 32'd17;
        RST_N       = 1'b0;
        halt        = 1'b0;
        mem_rd_data = '0;
        fetch_addr  = '0;
        halt_left   = 0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i]       = next_rand();
            model_ram[i] = ram[i];
        end
        for (int r = 0; r < rv_pkg::REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        build_program();
        inst_data = prog[0];

        repeat (10) @(posedge CK_REF);
        assert (inst_addr == '0) else
            report_failure($sformatf("FAILED inst_addr: got %h expected %h", inst_addr, 0));
        assert (mem_read_wrn == 1'b1) else
            report_failure($sformatf("FAILED mem_read_wrn: got %h expected %h", mem_read_wrn, 1));
        assert (mem_addr == '0) else
            report_failure($sformatf("FAILED mem_addr: got %h expected %h", mem_addr, 0));
        assert (mem_wr_data == '0) else
            report_failure($sformatf("FAILED mem_wr_data: got %h expected %h", mem_wr_data, 0));
        RST_N <= 1'b1;

        cycles = 0;
        while (exp_addr_q.size() != 0) begin
            @(negedge CK_REF);
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                report_failure("Timed out waiting for the program's stores to reach the bus");
            end
        end
        repeat (40) @(negedge CK_REF);   // Any extra store fails in the checker
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* logic/rv_core.sv */
`timescale 1ns/1ns

module rv_core (
    input  logic              CK_REF,
    input  logic              RST_N,
    input  logic              halt,          // Stalls every stage while high
    input  rv_pkg::word_t     inst_data,
    input  rv_pkg::word_t     mem_rd_data,
    output rv_pkg::word_t     inst_addr,
    output logic              mem_read_wrn,
    output rv_pkg::mem_addr_t mem_addr,
    output rv_pkg::word_t     mem_wr_data
);

    // Fetch to decode
    rv_pkg::word_t    instr;
    // Register file
    rv_pkg::reg_idx_t rs1_idx, rs2_idx, reg_wr_idx;
    rv_pkg::word_t    rs1_data, rs2_data, reg_wr_data;
    logic             reg_wr_en;
    // Decode to execute
    rv_pkg::alu_op_e  ex_alu_op;
    rv_pkg::word_t    ex_a, ex_b, ex_store_data;
    rv_pkg::reg_idx_t ex_rd;
    rv_pkg::mem_op_e  ex_mem_op;
    rv_pkg::size_e    ex_size;
    logic             ex_wb_en, ex_wb_from_alu;
    // Execute to memory
    rv_pkg::word_t    mem_result, mem_store_data;
    rv_pkg::reg_idx_t mem_rd;
    rv_pkg::mem_op_e  mem_mem_op;
    rv_pkg::size_e    mem_size;
    logic             mem_wb_en, mem_wb_from_alu;
    // Memory to write-back
    rv_pkg::word_t    wb_result;
    rv_pkg::reg_idx_t wb_rd;
    rv_pkg::size_e    wb_size;
    logic             wb_en, wb_from_alu;

    rv_fetch u_fetch (
        .CK_REF(CK_REF), .RST_N(RST_N), .halt(halt),
        .inst_data(inst_data), .inst_addr(inst_addr), .instr(instr)
    );

    rv_regfile u_regfile (
        .CK_REF(CK_REF), .RST_N(RST_N),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(reg_wr_en), .wr_idx(reg_wr_idx), .wr_data(reg_wr_data)
    );

    rv_decode u_decode (
        .CK_REF(CK_REF), .RST_N(RST_N), .halt(halt), .instr(instr),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_alu_op(ex_alu_op), .ex_a(ex_a), .ex_b(ex_b), .ex_rd(ex_rd),
        .ex_mem_op(ex_mem_op), .ex_size(ex_size), .ex_wb_en(ex_wb_en),
        .ex_wb_from_alu(ex_wb_from_alu), .ex_store_data(ex_store_data)
    );

    rv_alu u_alu (
        .CK_REF(CK_REF), .RST_N(RST_N), .halt(halt),
        .alu_op(ex_alu_op), .a(ex_a), .b(ex_b), .rd(ex_rd), .mem_op(ex_mem_op),
        .size(ex_size), .wb_en(ex_wb_en), .wb_from_alu(ex_wb_from_alu),
        .store_data(ex_store_data),
        .mem_result(mem_result), .mem_rd(mem_rd), .mem_mem_op(mem_mem_op),
        .mem_size(mem_size), .mem_wb_en(mem_wb_en), .mem_wb_from_alu(mem_wb_from_alu),
        .mem_store_data(mem_store_data)
    );

    rv_mem_stage u_mem_stage (
        .CK_REF(CK_REF), .RST_N(RST_N), .halt(halt),
        .result(mem_result), .rd(mem_rd), .mem_op(mem_mem_op), .size(mem_size),
        .wb_en(mem_wb_en), .wb_from_alu(mem_wb_from_alu), .store_data(mem_store_data),
        .mem_read_wrn(mem_read_wrn), .mem_addr(mem_addr), .mem_wr_data(mem_wr_data),
        .wb_result(wb_result), .wb_rd(wb_rd), .wb_size(wb_size),
        .wb_wb_en(wb_en), .wb_wb_from_alu(wb_from_alu)
    );

    rv_writeback u_writeback (
        .result(wb_result), .rd(wb_rd), .size(wb_size), .wb_en(wb_en),
        .wb_from_alu(wb_from_alu), .mem_rd_data(mem_rd_data),
        .reg_wr_en(reg_wr_en), .reg_wr_idx(reg_wr_idx), .reg_wr_data(reg_wr_data)
    );

endmodule

/* logic/rv_writeback.sv */
`timescale 1ns/1ns

module rv_writeback (
    input  rv_pkg::word_t    result,        // ALU result from the memory stage register
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::size_e    size,
    input  logic             wb_en,
    input  logic             wb_from_alu,
    input  rv_pkg::word_t    mem_rd_data,   // Load word, valid since the previous edge
    output logic             reg_wr_en,
    output rv_pkg::reg_idx_t reg_wr_idx,
    output rv_pkg::word_t    reg_wr_data
);

    rv_pkg::word_t load_sized;

    // ******************************
    // Load extension
    // ******************************
    always_comb begin
        case (size)
            rv_pkg::SIZE_HALF_U: load_sized = {16'd0, mem_rd_data[15:0]};
            rv_pkg::SIZE_HALF_S: load_sized = {{16{mem_rd_data[15]}}, mem_rd_data[15:0]};
            rv_pkg::SIZE_BYTE_U: load_sized = {24'd0, mem_rd_data[7:0]};
            rv_pkg::SIZE_BYTE_S: load_sized = {{24{mem_rd_data[7]}}, mem_rd_data[7:0]};
            default:             load_sized = mem_rd_data;   // LW
        endcase
    end

    // Register file takes these at the next edge
    assign reg_wr_en   = wb_en;
    assign reg_wr_idx  = rd;
    assign reg_wr_data = wb_from_alu ? result : load_sized;

endmodule

/* logic/rv_mem_stage.sv */
`timescale 1ns/1ns

module rv_mem_stage (
    input  logic              CK_REF,
    input  logic              RST_N,
    input  logic              halt,
    input  rv_pkg::word_t     result,
    input  rv_pkg::reg_idx_t  rd,
    input  rv_pkg::mem_op_e   mem_op,
    input  rv_pkg::size_e     size,
    input  logic              wb_en,
    input  logic              wb_from_alu,
    input  rv_pkg::word_t     store_data,
    // Data memory port, combinational from the execute register
    output logic              mem_read_wrn,   // Low for a whole store cycle
    output rv_pkg::mem_addr_t mem_addr,
    output rv_pkg::word_t     mem_wr_data,
    // Memory-to-writeback register
    output rv_pkg::word_t     wb_result,
    output rv_pkg::reg_idx_t  wb_rd,
    output rv_pkg::size_e     wb_size,
    output logic              wb_wb_en,
    output logic              wb_wb_from_alu
);

    rv_pkg::word_t store_sized;

    // SB and SH put their value on the bus sign-extended
    always_comb begin
        case (size)
            rv_pkg::SIZE_BYTE_S: store_sized = {{24{store_data[7]}}, store_data[7:0]};
            rv_pkg::SIZE_HALF_S: store_sized = {{16{store_data[15]}}, store_data[15:0]};
            default:             store_sized = store_data;
        endcase
    end

    always_comb begin
        mem_read_wrn = 1'b1;   // Idle bus reads address zero
        mem_addr     = '0;
        mem_wr_data  = '0;
        if (mem_op == rv_pkg::MEM_LOAD) begin
            mem_addr = result[rv_pkg::MEM_ADDR_W-1:0];
        end else if (mem_op == rv_pkg::MEM_STORE) begin
            mem_read_wrn = 1'b0;
            mem_addr     = result[rv_pkg::MEM_ADDR_W-1:0];
            mem_wr_data  = store_sized;
        end
    end

    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            wb_result      <= '0;
            wb_rd          <= '0;
            wb_size        <= rv_pkg::SIZE_WORD;
            wb_wb_en       <= 1'b0;
            wb_wb_from_alu <= 1'b1;
        end else if (!halt) begin
            wb_result      <= result;
            wb_rd          <= rd;
            wb_size        <= size;
            wb_wb_en       <= wb_en;
            wb_wb_from_alu <= wb_from_alu;
        end
    end

endmodule

/* logic/rv_alu.sv */
`timescale 1ns/1ns

module rv_alu (
    input  logic             CK_REF,
    input  logic             RST_N,
    input  logic             halt,
    input  rv_pkg::alu_op_e  alu_op,
    input  rv_pkg::word_t    a,
    input  rv_pkg::word_t    b,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::mem_op_e  mem_op,
    input  rv_pkg::size_e    size,
    input  logic             wb_en,
    input  logic             wb_from_alu,
    input  rv_pkg::word_t    store_data,
    output rv_pkg::word_t    mem_result,   // ALU result, also the memory address
    output rv_pkg::reg_idx_t mem_rd,
    output rv_pkg::mem_op_e  mem_mem_op,
    output rv_pkg::size_e    mem_size,
    output logic             mem_wb_en,
    output logic             mem_wb_from_alu,
    output rv_pkg::word_t    mem_store_data
);

    rv_pkg::word_t alu_out;
    logic [4:0]    shamt;

    assign shamt = b[4:0];   // Shift amount from low bits only

    always_comb begin
        case (alu_op)
            rv_pkg::ALU_SUB:  alu_out = a - b;
            rv_pkg::ALU_SLL:  alu_out = a << shamt;
            rv_pkg::ALU_SLT:  alu_out = {31'd0, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU: alu_out = {31'd0, a < b};
            rv_pkg::ALU_XOR:  alu_out = a ^ b;
            rv_pkg::ALU_SRL:  alu_out = a >> shamt;
            rv_pkg::ALU_SRA:  alu_out = $signed(a) >>> shamt;   // Sign fill
            rv_pkg::ALU_OR:   alu_out = a | b;
            rv_pkg::ALU_AND:  alu_out = a & b;
            default:          alu_out = a + b;   // ALU_ADD
        endcase
    end

    // Execute-to-memory register
    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            mem_result      <= '0;
            mem_rd          <= '0;
            mem_mem_op      <= rv_pkg::MEM_NOP;
            mem_size        <= rv_pkg::SIZE_WORD;
            mem_wb_en       <= 1'b0;
            mem_wb_from_alu <= 1'b1;
            mem_store_data  <= '0;
        end else if (!halt) begin
            mem_result      <= alu_out;
            mem_rd          <= rd;
            mem_mem_op      <= mem_op;
            mem_size        <= size;
            mem_wb_en       <= wb_en;
            mem_wb_from_alu <= wb_from_alu;
            mem_store_data  <= store_data;
        end
    end

endmodule

/* logic/rv_decode.sv */
`timescale 1ns/1ns

module rv_decode (
    input  logic             CK_REF,
    input  logic             RST_N,
    input  logic             halt,
    input  rv_pkg::word_t    instr,
    // Register file read side
    output rv_pkg::reg_idx_t rs1_idx,
    output rv_pkg::reg_idx_t rs2_idx,
    input  rv_pkg::word_t    rs1_data,
    input  rv_pkg::word_t    rs2_data,
    // Decode-to-execute register
    output rv_pkg::alu_op_e  ex_alu_op,
    output rv_pkg::word_t    ex_a,
    output rv_pkg::word_t    ex_b,
    output rv_pkg::reg_idx_t ex_rd,
    output rv_pkg::mem_op_e  ex_mem_op,
    output rv_pkg::size_e    ex_size,
    output logic             ex_wb_en,         // Register write at write-back
    output logic             ex_wb_from_alu,   // 1 ALU result, 0 load data
    output rv_pkg::word_t    ex_store_data
);

    logic [2:0]       funct3;
    rv_pkg::word_t    imm_i, imm_s;
    rv_pkg::alu_op_e  alu_op_d;
    rv_pkg::word_t    a_d, b_d, store_d;
    rv_pkg::reg_idx_t rd_d;
    rv_pkg::mem_op_e  mem_op_d;
    rv_pkg::size_e    size_d;
    logic             wb_en_d, wb_from_alu_d;

    assign funct3  = instr[14:12];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];

    // Sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    // ******************************
    // Field decode
    // ******************************
    always_comb begin
        // Inactive defaults, used as-is for bubble and unknown opcodes
        alu_op_d      = rv_pkg::ALU_ADD;
        a_d           = rs1_data;
        b_d           = imm_i;
        rd_d          = '0;
        mem_op_d      = rv_pkg::MEM_NOP;
        size_d        = rv_pkg::SIZE_WORD;
        wb_en_d       = 1'b0;
        wb_from_alu_d = 1'b1;
        store_d       = '0;

        // Size from funct3, same map for loads and stores
        case (funct3)
            3'b000:  size_d = rv_pkg::SIZE_BYTE_S;
            3'b001:  size_d = rv_pkg::SIZE_HALF_S;
            3'b100:  size_d = rv_pkg::SIZE_BYTE_U;
            3'b101:  size_d = rv_pkg::SIZE_HALF_U;
            default: size_d = rv_pkg::SIZE_WORD;
        endcase

        // ALU op, bit 30 picks SUB only on register-register
        case (funct3)
            3'b000:  alu_op_d = (instr[6:0] == rv_pkg::OPC_OP && instr[30]) ?
                                rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  alu_op_d = rv_pkg::ALU_SLL;
            3'b010:  alu_op_d = rv_pkg::ALU_SLT;
            3'b011:  alu_op_d = rv_pkg::ALU_SLTU;
            3'b100:  alu_op_d = rv_pkg::ALU_XOR;
            3'b101:  alu_op_d = instr[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  alu_op_d = rv_pkg::ALU_OR;
            default: alu_op_d = rv_pkg::ALU_AND;
        endcase

        case (instr[6:0])
            rv_pkg::OPC_OP_IMM: begin
                rd_d    = instr[11:7];
                wb_en_d = 1'b1;
            end
            rv_pkg::OPC_OP: begin
                rd_d    = instr[11:7];
                b_d     = rs2_data;
                wb_en_d = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                alu_op_d      = rv_pkg::ALU_ADD;   // Address = rs1 + imm
                rd_d          = instr[11:7];
                mem_op_d      = rv_pkg::MEM_LOAD;
                wb_en_d       = 1'b1;
                wb_from_alu_d = 1'b0;
            end
            rv_pkg::OPC_STORE: begin
                alu_op_d = rv_pkg::ALU_ADD;
                b_d      = imm_s;
                mem_op_d = rv_pkg::MEM_STORE;
                store_d  = rs2_data;   // Sized later in the memory stage
            end
            default: begin
                // Bubble: nothing reaches memory or the register file
                alu_op_d = rv_pkg::ALU_ADD;
                size_d   = rv_pkg::SIZE_WORD;
            end
        endcase
    end

    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            ex_alu_op      <= rv_pkg::ALU_ADD;
            ex_a           <= '0;
            ex_b           <= '0;
            ex_rd          <= '0;
            ex_mem_op      <= rv_pkg::MEM_NOP;
            ex_size        <= rv_pkg::SIZE_WORD;
            ex_wb_en       <= 1'b0;
            ex_wb_from_alu <= 1'b1;
            ex_store_data  <= '0;
        end else if (!halt) begin
            ex_alu_op      <= alu_op_d;
            ex_a           <= a_d;
            ex_b           <= b_d;
            ex_rd          <= rd_d;
            ex_mem_op      <= mem_op_d;
            ex_size        <= size_d;
            ex_wb_en       <= wb_en_d;
            ex_wb_from_alu <= wb_from_alu_d;
            ex_store_data  <= store_d;
        end
    end

endmodule

/* logic/rv_regfile.sv */
`timescale 1ns/1ns

module rv_regfile (
    input  logic            CK_REF,
    input  logic            RST_N,
    input  rv_pkg::reg_idx_t rs1_idx,
    input  rv_pkg::reg_idx_t rs2_idx,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data,
    input  logic            wr_en,
    input  rv_pkg::reg_idx_t wr_idx,
    input  rv_pkg::word_t    wr_data
);

    rv_pkg::word_t regs [rv_pkg::REG_COUNT];

    // Reads are combinational so decode sees a write from the same edge
    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            for (int i = 0; i < rv_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin   // x0 never written, reads zero
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

/* logic/rv_fetch.sv */
`timescale 1ns/1ns

module rv_fetch (
    input  logic          CK_REF,
    input  logic          RST_N,
    input  logic          halt,        // Stall level, holds PC and IR
    input  rv_pkg::word_t inst_data,   // Word at inst_addr
    output rv_pkg::word_t inst_addr,
    output rv_pkg::word_t instr        // Instruction register toward decode
);

    rv_pkg::word_t pc;

    assign inst_addr = pc;   // PC drives the code memory directly

    always_ff @(posedge CK_REF or negedge RST_N) begin
        if (!RST_N) begin
            pc    <= '0;
            instr <= rv_pkg::BUBBLE_WORD;   // Pipeline starts empty
        end else if (!halt) begin
            pc    <= pc + rv_pkg::word_t'(rv_pkg::INST_STEP);
            instr <= inst_data;   // Captured as PC moves past its address
        end
    end

endmodule

/* logic/rv_pkg.sv */
package rv_pkg;

    // ******************************
    // Widths and pipeline constants
    // ******************************
    localparam int XLEN       = 32;   // Data path width
    localparam int REG_COUNT  = 32;   // x0 .. x31
    localparam int MEM_ADDR_W = 16;   // Data memory address width
    localparam int INST_STEP  = 4;    // Bytes per instruction

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [4:0]            reg_idx_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    localparam word_t BUBBLE_WORD = '0;   // All-zero word, no effect on any stage

    // Major opcodes kept in this core, anything else decodes as a bubble
    typedef enum logic [6:0] {
        OPC_BUBBLE = 7'b000_0000,
        OPC_LOAD   = 7'b000_0011,
        OPC_OP_IMM = 7'b001_0011,
        OPC_STORE  = 7'b010_0011,
        OPC_OP     = 7'b011_0011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NOP   = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // Access size, also carries the extension kind for loads and stores
    typedef enum logic [2:0] {
        SIZE_WORD   = 3'd0,
        SIZE_HALF_U = 3'd1,
        SIZE_HALF_S = 3'd2,
        SIZE_BYTE_U = 3'd3,
        SIZE_BYTE_S = 3'd4
    } size_e;

endpackage
